// ==== design/fabric_pkg.sv ====
`default_nettype none

package fabric_pkg;

    // bus widths
    localparam int addr_w  = 32;
    localparam int data_w  = 32;
    localparam int id_w    = 4;
    localparam int len_w   = 8;
    localparam int strb_w  = 4;
    localparam int size_w  = 3;
    localparam int burst_w = 2;
    localparam int resp_w  = 2;
    localparam int mtime_w = 64;

    // largest arsize the 32-bit data bus can carry (4 bytes)
    localparam logic [size_w-1:0] size_max = 3'd2;

    // reserved AXI burst encoding
    localparam logic [burst_w-1:0] burst_rsvd = 2'b11;

    // mtime low word, high word sits 4 bytes above
    localparam logic [addr_w-1:0] clint_base = 32'h0200_0000;

    localparam logic [resp_w-1:0] resp_okay   = 2'b00;
    localparam logic [resp_w-1:0] resp_slverr = 2'b10;

    typedef enum logic [1:0] {
        grant_idle,
        grant_ifu,
        grant_lsu
    } grant_e;

endpackage

`default_nettype wire

// ==== design/bus_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module bus_arbiter
    import fabric_pkg::*;
(
    input  wire                 clk,
    input  wire                 rst,

    // IFU read port
    input  wire                 ifu_arvalid,
    input  wire  [addr_w-1:0]   ifu_araddr,
    input  wire  [id_w-1:0]     ifu_arid,
    input  wire  [len_w-1:0]    ifu_arlen,
    input  wire  [size_w-1:0]   ifu_arsize,
    input  wire  [burst_w-1:0]  ifu_arburst,
    output logic                ifu_arready,
    input  wire                 ifu_rready,
    output logic                ifu_rvalid,
    output logic [resp_w-1:0]   ifu_rresp,
    output logic [data_w-1:0]   ifu_rdata,
    output logic                ifu_rlast,
    output logic [id_w-1:0]     ifu_rid,

    // LSU port
    input  wire                 lsu_arvalid,
    input  wire  [addr_w-1:0]   lsu_araddr,
    input  wire  [id_w-1:0]     lsu_arid,
    input  wire  [len_w-1:0]    lsu_arlen,
    input  wire  [size_w-1:0]   lsu_arsize,
    input  wire  [burst_w-1:0]  lsu_arburst,
    output logic                lsu_arready,
    input  wire                 lsu_rready,
    output logic                lsu_rvalid,
    output logic [resp_w-1:0]   lsu_rresp,
    output logic [data_w-1:0]   lsu_rdata,
    output logic                lsu_rlast,
    output logic [id_w-1:0]     lsu_rid,
    input  wire                 lsu_awvalid,
    input  wire  [addr_w-1:0]   lsu_awaddr,
    input  wire  [id_w-1:0]     lsu_awid,
    input  wire  [len_w-1:0]    lsu_awlen,
    input  wire  [size_w-1:0]   lsu_awsize,
    input  wire  [burst_w-1:0]  lsu_awburst,
    output logic                lsu_awready,
    input  wire                 lsu_wvalid,
    input  wire  [data_w-1:0]   lsu_wdata,
    input  wire  [strb_w-1:0]   lsu_wstrb,
    input  wire                 lsu_wlast,
    output logic                lsu_wready,
    input  wire                 lsu_bready,
    output logic                lsu_bvalid,
    output logic [resp_w-1:0]   lsu_bresp,
    output logic [id_w-1:0]     lsu_bid,

    // external memory master
    input  wire                 io_master_awready,
    output logic                io_master_awvalid,
    output logic [addr_w-1:0]   io_master_awaddr,
    output logic [id_w-1:0]     io_master_awid,
    output logic [len_w-1:0]    io_master_awlen,
    output logic [size_w-1:0]   io_master_awsize,
    output logic [burst_w-1:0]  io_master_awburst,
    input  wire                 io_master_wready,
    output logic                io_master_wvalid,
    output logic [data_w-1:0]   io_master_wdata,
    output logic [strb_w-1:0]   io_master_wstrb,
    output logic                io_master_wlast,
    output logic                io_master_bready,
    input  wire                 io_master_bvalid,
    input  wire  [resp_w-1:0]   io_master_bresp,
    input  wire  [id_w-1:0]     io_master_bid,
    input  wire                 io_master_arready,
    output logic                io_master_arvalid,
    output logic [addr_w-1:0]   io_master_araddr,
    output logic [id_w-1:0]     io_master_arid,
    output logic [len_w-1:0]    io_master_arlen,
    output logic [size_w-1:0]   io_master_arsize,
    output logic [burst_w-1:0]  io_master_arburst,
    output logic                io_master_rready,
    input  wire                 io_master_rvalid,
    input  wire  [resp_w-1:0]   io_master_rresp,
    input  wire  [data_w-1:0]   io_master_rdata,
    input  wire                 io_master_rlast,
    input  wire  [id_w-1:0]     io_master_rid,

    // CLINT read slave
    output logic                clint_arvalid,
    output logic [addr_w-1:0]   clint_araddr,
    output logic [id_w-1:0]     clint_arid,
    output logic [len_w-1:0]    clint_arlen,
    output logic [size_w-1:0]   clint_arsize,
    output logic [burst_w-1:0]  clint_arburst,
    input  wire                 clint_arready,
    output logic                clint_rready,
    input  wire                 clint_rvalid,
    input  wire  [resp_w-1:0]   clint_rresp,
    input  wire  [data_w-1:0]   clint_rdata,
    input  wire                 clint_rlast,
    input  wire  [id_w-1:0]     clint_rid
);

    grant_e state;
    grant_e next_state;
    logic   clint_sel;  // LSU read targets mtime
    logic   ifu_done;
    logic   lsu_done;

    // grant ends on the owner's own last handshake
    assign ifu_done = ifu_rvalid & ifu_rready & ifu_rlast;
    assign lsu_done = (lsu_rvalid & lsu_rready & lsu_rlast) | (lsu_bvalid & lsu_bready);

    always_comb begin
        next_state = state;
        case (state)
            grant_idle: begin
                if (lsu_arvalid | lsu_awvalid) begin  // LSU wins ties
                    next_state = grant_lsu;
                end else if (ifu_arvalid) begin
                    next_state = grant_ifu;
                end
            end
            grant_ifu: if (ifu_done) next_state = grant_idle;
            grant_lsu: if (lsu_done) next_state = grant_idle;
            default:   next_state = grant_idle;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= grant_idle;
            clint_sel <= 1'b0;
        end else begin
            state <= next_state;
            if (state == grant_idle) begin
                clint_sel <= lsu_arvalid &
                             ((lsu_araddr == clint_base) || (lsu_araddr == clint_base + 4));
            end
        end
    end

    // payloads follow the owner, only the handshakes are gated
    assign io_master_araddr  = (state == grant_ifu) ? ifu_araddr  : lsu_araddr;
    assign io_master_arid    = (state == grant_ifu) ? ifu_arid    : lsu_arid;
    assign io_master_arlen   = (state == grant_ifu) ? ifu_arlen   : lsu_arlen;
    assign io_master_arsize  = (state == grant_ifu) ? ifu_arsize  : lsu_arsize;
    assign io_master_arburst = (state == grant_ifu) ? ifu_arburst : lsu_arburst;

    assign io_master_awaddr  = lsu_awaddr;   // only the LSU writes
    assign io_master_awid    = lsu_awid;
    assign io_master_awlen   = lsu_awlen;
    assign io_master_awsize  = lsu_awsize;
    assign io_master_awburst = lsu_awburst;
    assign io_master_wdata   = lsu_wdata;
    assign io_master_wstrb   = lsu_wstrb;
    assign io_master_wlast   = lsu_wlast;

    assign clint_araddr  = lsu_araddr;
    assign clint_arid    = lsu_arid;
    assign clint_arlen   = lsu_arlen;
    assign clint_arsize  = lsu_arsize;
    assign clint_arburst = lsu_arburst;

    assign ifu_rresp = io_master_rresp;
    assign ifu_rdata = io_master_rdata;
    assign ifu_rlast = io_master_rlast;
    assign ifu_rid   = io_master_rid;

    assign lsu_rresp = clint_sel ? clint_rresp : io_master_rresp;
    assign lsu_rdata = clint_sel ? clint_rdata : io_master_rdata;
    assign lsu_rlast = clint_sel ? clint_rlast : io_master_rlast;
    assign lsu_rid   = clint_sel ? clint_rid   : io_master_rid;

    assign lsu_bresp = io_master_bresp;
    assign lsu_bid   = io_master_bid;

    always_comb begin
        ifu_arready       = 1'b0;
        ifu_rvalid        = 1'b0;
        lsu_arready       = 1'b0;
        lsu_rvalid        = 1'b0;
        lsu_awready       = 1'b0;
        lsu_wready        = 1'b0;
        lsu_bvalid        = 1'b0;
        io_master_arvalid = 1'b0;
        io_master_rready  = 1'b0;
        io_master_awvalid = 1'b0;
        io_master_wvalid  = 1'b0;
        io_master_bready  = 1'b0;
        clint_arvalid     = 1'b0;
        clint_rready      = 1'b0;
        case (state)
            grant_ifu: begin
                io_master_arvalid = ifu_arvalid;
                io_master_rready  = ifu_rready;
                ifu_arready       = io_master_arready;
                ifu_rvalid        = io_master_rvalid;
            end
            grant_lsu: begin
                if (clint_sel) begin
                    clint_arvalid = lsu_arvalid;
                    clint_rready  = lsu_rready;
                    lsu_arready   = clint_arready;
                    lsu_rvalid    = clint_rvalid;
                end else begin
                    io_master_arvalid = lsu_arvalid;
                    io_master_rready  = lsu_rready;
                    io_master_awvalid = lsu_awvalid;
                    io_master_wvalid  = lsu_wvalid;
                    io_master_bready  = lsu_bready;
                    lsu_arready       = io_master_arready;
                    lsu_rvalid        = io_master_rvalid;
                    lsu_awready       = io_master_awready;
                    lsu_wready        = io_master_wready;
                    lsu_bvalid        = io_master_bvalid;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== design/clint_timer.sv ====
`timescale 1ns/100ps
`default_nettype none

module clint_timer
    import fabric_pkg::*;
(
    input  wire                 clk,
    input  wire                 rst,

    input  wire                 arvalid,
    input  wire  [addr_w-1:0]   araddr,
    input  wire  [id_w-1:0]     arid,
    input  wire  [len_w-1:0]    arlen,
    input  wire  [size_w-1:0]   arsize,
    input  wire  [burst_w-1:0]  arburst,
    output logic                arready,

    input  wire                 rready,
    output logic                rvalid,
    output logic [resp_w-1:0]   rresp,
    output logic [data_w-1:0]   rdata,
    output logic                rlast,
    output logic [id_w-1:0]     rid
);

    logic [mtime_w-1:0] mtime;
    logic               ar_fire;
    logic               bad_req;

    assign arready = ~rvalid;  // one response in flight
    assign ar_fire = arvalid & arready;
    assign rlast   = rvalid;   // always a single beat

    // bursts, oversized beats and reserved burst types are refused
    assign bad_req = (arlen != '0) || (arsize > size_max) || (arburst == burst_rsvd);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mtime <= '0;
        end else begin
            mtime <= mtime + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rvalid <= 1'b0;
        end else if (ar_fire) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    // response payload, captured with the AR beat
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            rdata <= araddr[2] ? mtime[63:32] : mtime[31:0];
            rid   <= arid;
            rresp <= bad_req ? resp_slverr : resp_okay;
        end
    end

endmodule

`default_nettype wire

// ==== design/mem_fabric_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_fabric_top
    import fabric_pkg::*;
(
    input  wire                 clk,
    input  wire                 rst,

    input  wire                 ifu_arvalid,
    input  wire  [addr_w-1:0]   ifu_araddr,
    input  wire  [id_w-1:0]     ifu_arid,
    input  wire  [len_w-1:0]    ifu_arlen,
    input  wire  [size_w-1:0]   ifu_arsize,
    input  wire  [burst_w-1:0]  ifu_arburst,
    output wire                 ifu_arready,
    input  wire                 ifu_rready,
    output wire                 ifu_rvalid,
    output wire  [resp_w-1:0]   ifu_rresp,
    output wire  [data_w-1:0]   ifu_rdata,
    output wire                 ifu_rlast,
    output wire  [id_w-1:0]     ifu_rid,

    input  wire                 lsu_arvalid,
    input  wire  [addr_w-1:0]   lsu_araddr,
    input  wire  [id_w-1:0]     lsu_arid,
    input  wire  [len_w-1:0]    lsu_arlen,
    input  wire  [size_w-1:0]   lsu_arsize,
    input  wire  [burst_w-1:0]  lsu_arburst,
    output wire                 lsu_arready,
    input  wire                 lsu_rready,
    output wire                 lsu_rvalid,
    output wire  [resp_w-1:0]   lsu_rresp,
    output wire  [data_w-1:0]   lsu_rdata,
    output wire                 lsu_rlast,
    output wire  [id_w-1:0]     lsu_rid,
    input  wire                 lsu_awvalid,
    input  wire  [addr_w-1:0]   lsu_awaddr,
    input  wire  [id_w-1:0]     lsu_awid,
    input  wire  [len_w-1:0]    lsu_awlen,
    input  wire  [size_w-1:0]   lsu_awsize,
    input  wire  [burst_w-1:0]  lsu_awburst,
    output wire                 lsu_awready,
    input  wire                 lsu_wvalid,
    input  wire  [data_w-1:0]   lsu_wdata,
    input  wire  [strb_w-1:0]   lsu_wstrb,
    input  wire                 lsu_wlast,
    output wire                 lsu_wready,
    input  wire                 lsu_bready,
    output wire                 lsu_bvalid,
    output wire  [resp_w-1:0]   lsu_bresp,
    output wire  [id_w-1:0]     lsu_bid,

    input  wire                 io_master_awready,
    output wire                 io_master_awvalid,
    output wire  [addr_w-1:0]   io_master_awaddr,
    output wire  [id_w-1:0]     io_master_awid,
    output wire  [len_w-1:0]    io_master_awlen,
    output wire  [size_w-1:0]   io_master_awsize,
    output wire  [burst_w-1:0]  io_master_awburst,
    input  wire                 io_master_wready,
    output wire                 io_master_wvalid,
    output wire  [data_w-1:0]   io_master_wdata,
    output wire  [strb_w-1:0]   io_master_wstrb,
    output wire                 io_master_wlast,
    output wire                 io_master_bready,
    input  wire                 io_master_bvalid,
    input  wire  [resp_w-1:0]   io_master_bresp,
    input  wire  [id_w-1:0]     io_master_bid,
    input  wire                 io_master_arready,
    output wire                 io_master_arvalid,
    output wire  [addr_w-1:0]   io_master_araddr,
    output wire  [id_w-1:0]     io_master_arid,
    output wire  [len_w-1:0]    io_master_arlen,
    output wire  [size_w-1:0]   io_master_arsize,
    output wire  [burst_w-1:0]  io_master_arburst,
    output wire                 io_master_rready,
    input  wire                 io_master_rvalid,
    input  wire  [resp_w-1:0]   io_master_rresp,
    input  wire  [data_w-1:0]   io_master_rdata,
    input  wire                 io_master_rlast,
    input  wire  [id_w-1:0]     io_master_rid
);

    // arbiter to timer
    wire                clint_arvalid;
    wire [addr_w-1:0]   clint_araddr;
    wire [id_w-1:0]     clint_arid;
    wire [len_w-1:0]    clint_arlen;
    wire [size_w-1:0]   clint_arsize;
    wire [burst_w-1:0]  clint_arburst;
    wire                clint_arready;
    wire                clint_rready;
    wire                clint_rvalid;
    wire [resp_w-1:0]   clint_rresp;
    wire [data_w-1:0]   clint_rdata;
    wire                clint_rlast;
    wire [id_w-1:0]     clint_rid;

    // port names match one to one
    bus_arbiter u_bus_arbiter (.*);

    clint_timer u_clint_timer (
        .clk     (clk),
        .rst     (rst),
        .arvalid (clint_arvalid),
        .araddr  (clint_araddr),
        .arid    (clint_arid),
        .arlen   (clint_arlen),
        .arsize  (clint_arsize),
        .arburst (clint_arburst),
        .arready (clint_arready),
        .rready  (clint_rready),
        .rvalid  (clint_rvalid),
        .rresp   (clint_rresp),
        .rdata   (clint_rdata),
        .rlast   (clint_rlast),
        .rid     (clint_rid)
    );

endmodule

`default_nettype wire

// ==== verif/fabric_properties.sv ====
`timescale 1ns/100ps
`default_nettype none

module fabric_properties
    import fabric_pkg::*;
(
    input wire                clk,
    input wire                rst,
    input wire [1:0]          state,
    input wire                ifu_rvalid,
    input wire                clint_arvalid,
    input wire                io_master_arvalid,
    input wire                io_master_arready,
    input wire [addr_w-1:0]   io_master_araddr,
    input wire                io_master_awvalid,
    input wire                io_master_awready,
    input wire                io_master_wvalid,
    input wire                io_master_wready
);

    // one read target at a time
    ar_one_target: assert property (@(posedge clk) disable iff (rst)
        !(clint_arvalid && io_master_arvalid))
        else $error("AR raised toward CLINT and io_master together");

    io_ar_hold: assert property (@(posedge clk) disable iff (rst)
        io_master_arvalid && !io_master_arready |=> io_master_arvalid && $stable(io_master_araddr))
        else $error("io_master AR request dropped or changed before arready");

    io_aw_hold: assert property (@(posedge clk) disable iff (rst)
        io_master_awvalid && !io_master_awready |=> io_master_awvalid)
        else $error("io_master awvalid dropped before awready");

    io_w_hold: assert property (@(posedge clk) disable iff (rst)
        io_master_wvalid && !io_master_wready |=> io_master_wvalid)
        else $error("io_master wvalid dropped before wready");

    no_ifu_r_under_lsu: assert property (@(posedge clk) disable iff (rst)
        state == grant_lsu |-> !ifu_rvalid)
        else $error("IFU saw a read beat while the LSU held the bus");

endmodule

bind bus_arbiter fabric_properties u_fabric_properties (
    .clk               (clk),
    .rst               (rst),
    .state             (state),
    .ifu_rvalid        (ifu_rvalid),
    .clint_arvalid     (clint_arvalid),
    .io_master_arvalid (io_master_arvalid),
    .io_master_arready (io_master_arready),
    .io_master_araddr  (io_master_araddr),
    .io_master_awvalid (io_master_awvalid),
    .io_master_awready (io_master_awready),
    .io_master_wvalid  (io_master_wvalid),
    .io_master_wready  (io_master_wready)
);

`default_nettype wire

// ==== verif/tb_mem_fabric.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_mem_fabric
    import fabric_pkg::*;
();

    typedef struct packed {
        logic               lsu;    // 0 IFU, 1 LSU
        logic               wr;
        logic               race;   // IFU read raised in the same cycle
        logic [addr_w-1:0]  addr;
        logic [id_w-1:0]    id;
        logic [len_w-1:0]   len;
        logic [data_w-1:0]  wdata;
        logic [resp_w-1:0]  resp;
    } row_t;

    localparam int n_rows = 12;

    logic clk = 1'b0;
    logic rst = 1'b1;

    logic               ifu_arvalid, ifu_arready, ifu_rready, ifu_rvalid, ifu_rlast;
    logic               lsu_arvalid, lsu_arready, lsu_rready, lsu_rvalid, lsu_rlast;
    logic               lsu_awvalid, lsu_awready, lsu_wvalid, lsu_wready, lsu_wlast;
    logic               lsu_bready, lsu_bvalid;
    logic [addr_w-1:0]  ifu_araddr, lsu_araddr, lsu_awaddr;
    logic [id_w-1:0]    ifu_arid, ifu_rid, lsu_arid, lsu_rid, lsu_awid, lsu_bid;
    logic [len_w-1:0]   ifu_arlen, lsu_arlen, lsu_awlen;
    logic [size_w-1:0]  ifu_arsize, lsu_arsize, lsu_awsize;
    logic [burst_w-1:0] ifu_arburst, lsu_arburst, lsu_awburst;
    logic [resp_w-1:0]  ifu_rresp, lsu_rresp, lsu_bresp;
    logic [data_w-1:0]  ifu_rdata, lsu_rdata, lsu_wdata;
    logic [strb_w-1:0]  lsu_wstrb;

    logic               io_master_awvalid, io_master_wvalid, io_master_wlast;
    logic               io_master_bready, io_master_arvalid, io_master_rready;
    logic [addr_w-1:0]  io_master_awaddr, io_master_araddr;
    logic [id_w-1:0]    io_master_awid, io_master_arid;
    logic [len_w-1:0]   io_master_awlen, io_master_arlen;
    logic [size_w-1:0]  io_master_awsize, io_master_arsize;
    logic [burst_w-1:0] io_master_awburst, io_master_arburst;
    logic [data_w-1:0]  io_master_wdata;
    logic [strb_w-1:0]  io_master_wstrb;

    // memory model side
    logic               io_master_arready = 1'b0;
    logic               io_master_awready = 1'b0;
    logic               io_master_wready  = 1'b0;
    logic               io_master_rvalid  = 1'b0;
    logic               io_master_bvalid  = 1'b0;
    logic [data_w-1:0]  io_master_rdata   = '0;
    logic [id_w-1:0]    io_master_rid     = '0;
    logic [id_w-1:0]    io_master_bid     = '0;
    logic [resp_w-1:0]  io_master_rresp;
    logic [resp_w-1:0]  io_master_bresp;
    logic               io_master_rlast;

    logic [data_w-1:0]  mem [logic [addr_w-1:0]];      // model storage
    logic [data_w-1:0]  exp_mem [logic [addr_w-1:0]];  // what the tb expects it holds
    logic               aw_seen = 1'b0;
    logic               w_seen  = 1'b0;
    logic [addr_w-1:0]  aw_addr;
    logic [id_w-1:0]    aw_id;
    logic [data_w-1:0]  w_data;
    int                 io_ar_cycles = 0;
    int                 errors = 0;
    int                 checks = 0;
    row_t               rows [n_rows];

    assign io_master_rresp = resp_okay;
    assign io_master_bresp = resp_okay;
    assign io_master_rlast = 1'b1;  // single beats only

    mem_fabric_top i_mem_fabric_top (.*);

    always #50 clk = ~clk;

    // ready stalls about one cycle in four
    initial begin
        void'($urandom(44330));
        forever begin
            @(posedge clk);
            io_master_arready <= ($urandom % 4) != 0;
            io_master_awready <= ($urandom % 4) != 0;
            io_master_wready  <= ($urandom % 4) != 0;
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            if (io_master_rvalid && io_master_rready) io_master_rvalid <= 1'b0;
            if (io_master_arvalid && io_master_arready) begin
                io_master_rvalid <= 1'b1;
                io_master_rid    <= io_master_arid;
                io_master_rdata  <= mem.exists(io_master_araddr) ?
                                    mem[io_master_araddr] : ~io_master_araddr;
                check_value("io_master_arlen", io_master_arlen, 0);
                check_value("io_master_arsize", io_master_arsize, 3'd2);
                check_value("io_master_arburst", io_master_arburst, 2'b01);
            end
            if (io_master_bvalid && io_master_bready) io_master_bvalid <= 1'b0;
            if (aw_seen && w_seen) begin  // answer with B once both halves are in
                mem[aw_addr] = w_data;
                io_master_bvalid <= 1'b1;
                io_master_bid    <= aw_id;
                aw_seen          <= 1'b0;
                w_seen           <= 1'b0;
            end
            if (io_master_awvalid && io_master_awready) begin
                aw_seen <= 1'b1;
                aw_addr <= io_master_awaddr;
                aw_id   <= io_master_awid;
                check_value("io_master_awlen", io_master_awlen, 0);
                check_value("io_master_awsize", io_master_awsize, 3'd2);
                check_value("io_master_awburst", io_master_awburst, 2'b01);
            end
            if (io_master_wvalid && io_master_wready) begin
                w_seen <= 1'b1;
                w_data <= io_master_wdata;
                check_value("io_master_wstrb", io_master_wstrb, 4'hf);
                check_value("io_master_wlast", io_master_wlast, 1'b1);
            end
        end
    end

    always @(posedge clk) begin
        if (io_master_arvalid) io_ar_cycles <= io_ar_cycles + 1;
    end

    initial begin
        repeat (n_rows * 200) @(posedge clk);
        $display("watchdog expired, the bus stopped answering");
        $display("Regression failed");
        $finish;
    end

    function automatic logic [data_w-1:0] mem_word(input logic [addr_w-1:0] addr);
        return exp_mem.exists(addr) ? exp_mem[addr] : ~addr;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic bus_read(input logic lsu, input logic [addr_w-1:0] addr,
                            input logic [id_w-1:0] id, input logic [len_w-1:0] len,
                            output logic [data_w-1:0] data, output logic [id_w-1:0] rid,
                            output logic [resp_w-1:0] resp, output logic last);
        if (lsu) begin
            lsu_araddr  = addr;
            lsu_arid    = id;
            lsu_arlen   = len;
            lsu_arvalid = 1'b1;
            while (!lsu_arready) @(negedge clk);
            @(negedge clk);  // AR taken on the edge just passed
            lsu_arvalid = 1'b0;
            while (!lsu_rvalid) @(negedge clk);
            data = lsu_rdata;
            rid  = lsu_rid;
            resp = lsu_rresp;
            last = lsu_rlast;
        end else begin
            ifu_araddr  = addr;
            ifu_arid    = id;
            ifu_arlen   = len;
            ifu_arvalid = 1'b1;
            while (!ifu_arready) @(negedge clk);
            @(negedge clk);
            ifu_arvalid = 1'b0;
            while (!ifu_rvalid) @(negedge clk);
            data = ifu_rdata;
            rid  = ifu_rid;
            resp = ifu_rresp;
            last = ifu_rlast;
        end
        @(negedge clk);
    endtask

    task automatic bus_write(input logic [addr_w-1:0] addr, input logic [id_w-1:0] id,
                             input logic [data_w-1:0] data,
                             output logic [id_w-1:0] bid, output logic [resp_w-1:0] bresp);
        logic aw_go;
        logic w_go;
        aw_go       = 1'b0;
        w_go        = 1'b0;
        lsu_awaddr  = addr;
        lsu_awid    = id;
        lsu_wdata   = data;
        lsu_awvalid = 1'b1;
        lsu_wvalid  = 1'b1;
        while (lsu_awvalid || lsu_wvalid) begin
            @(negedge clk);
            if (aw_go) lsu_awvalid = 1'b0;
            if (w_go) lsu_wvalid = 1'b0;
            aw_go = lsu_awvalid && lsu_awready;
            w_go  = lsu_wvalid && lsu_wready;
        end
        while (!lsu_bvalid) @(negedge clk);
        bid   = lsu_bid;
        bresp = lsu_bresp;
        @(negedge clk);
    endtask

    initial begin
        row_t               r;
        logic               is_clint;
        logic               have_low;
        logic [data_w-1:0]  last_low;
        logic [data_w-1:0]  data, idata;
        logic [id_w-1:0]    rid, irid;
        logic [resp_w-1:0]  resp, iresp;
        logic               last, ilast;
        int                 ar_before;
        time                lsu_t, ifu_t;

        ifu_arvalid = 1'b0;
        ifu_araddr  = '0;
        ifu_arid    = '0;
        ifu_arlen   = '0;
        ifu_arsize  = 3'd2;
        ifu_arburst = 2'b01;
        ifu_rready  = 1'b1;
        lsu_arvalid = 1'b0;
        lsu_araddr  = '0;
        lsu_arid    = '0;
        lsu_arlen   = '0;
        lsu_arsize  = 3'd2;
        lsu_arburst = 2'b01;
        lsu_rready  = 1'b1;
        lsu_awvalid = 1'b0;
        lsu_awaddr  = '0;
        lsu_awid    = '0;
        lsu_awlen   = '0;
        lsu_awsize  = 3'd2;
        lsu_awburst = 2'b01;
        lsu_wvalid  = 1'b0;
        lsu_wdata   = '0;
        lsu_wstrb   = '1;
        lsu_wlast   = 1'b1;
        lsu_bready  = 1'b1;
        have_low    = 1'b0;
        last_low    = '0;

        //           lsu   wr    race  addr                 id    len   wdata          resp
        rows[0]  = '{1'b0, 1'b0, 1'b0, 32'h0000_1000,       4'h3, 8'd0, 32'h0,         resp_okay};
        rows[1]  = '{1'b1, 1'b1, 1'b0, 32'h0000_2000,       4'h5, 8'd0, 32'hdead_beef, resp_okay};
        rows[2]  = '{1'b1, 1'b0, 1'b0, 32'h0000_2000,       4'h6, 8'd0, 32'h0,         resp_okay};
        rows[3]  = '{1'b1, 1'b0, 1'b0, clint_base,          4'h1, 8'd0, 32'h0,         resp_okay};
        rows[4]  = '{1'b1, 1'b0, 1'b0, clint_base + 32'd4,  4'h2, 8'd0, 32'h0,         resp_okay};
        rows[5]  = '{1'b1, 1'b0, 1'b0, clint_base,          4'h3, 8'd0, 32'h0,         resp_okay};
        rows[6]  = '{1'b1, 1'b0, 1'b0, clint_base,          4'h4, 8'd3, 32'h0,       resp_slverr};
        rows[7]  = '{1'b1, 1'b0, 1'b1, 32'h0000_3000,       4'h7, 8'd0, 32'h0,         resp_okay};
        rows[8]  = '{1'b1, 1'b1, 1'b0, 32'h0000_4004,       4'h9, 8'd0, 32'h1234_5678, resp_okay};
        rows[9]  = '{1'b0, 1'b0, 1'b0, 32'h0000_4004,       4'ha, 8'd0, 32'h0,         resp_okay};
        rows[10] = '{1'b0, 1'b0, 1'b0, 32'h0000_5008,       4'hb, 8'd0, 32'h0,         resp_okay};
        rows[11] = '{1'b1, 1'b0, 1'b0, 32'h0000_1000,       4'hc, 8'd0, 32'h0,         resp_okay};

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < n_rows; i++) begin
            r         = rows[i];
            is_clint  = r.lsu && !r.wr && (r.addr == clint_base || r.addr == clint_base + 32'd4);
            ar_before = io_ar_cycles;
            if (r.wr) begin
                bus_write(r.addr, r.id, r.wdata, rid, resp);
                check_value("lsu_bid", rid, r.id);
                check_value("lsu_bresp", resp, r.resp);
                exp_mem[r.addr] = r.wdata;
                continue;
            end
            if (r.race) begin
                fork
                    begin
                        bus_read(1'b1, r.addr, r.id, r.len, data, rid, resp, last);
                        lsu_t = $time;
                    end
                    begin
                        bus_read(1'b0, r.addr + 32'h100, r.id + 4'h1, 8'd0,
                                 idata, irid, iresp, ilast);
                        ifu_t = $time;
                    end
                join
                if (lsu_t >= ifu_t) begin
                    errors++;
                    $display("LSU read did not finish ahead of the competing IFU read");
                end
                check_value("ifu_rdata", idata, mem_word(r.addr + 32'h100));
                check_value("ifu_rid", irid, r.id + 4'h1);
                check_value("ifu_rresp", iresp, resp_okay);
                check_value("ifu_rlast", ilast, 1'b1);
            end else begin
                bus_read(r.lsu, r.addr, r.id, r.len, data, rid, resp, last);
            end
            check_value(r.lsu ? "lsu_rid" : "ifu_rid", rid, r.id);
            check_value(r.lsu ? "lsu_rresp" : "ifu_rresp", resp, r.resp);
            check_value(r.lsu ? "lsu_rlast" : "ifu_rlast", last, 1'b1);
            if (!is_clint) begin
                check_value(r.lsu ? "lsu_rdata" : "ifu_rdata", data, mem_word(r.addr));
            end else begin
                check_value("io_master_arvalid cycles", io_ar_cycles - ar_before, 0);
                if (r.resp == resp_okay && r.addr[2]) begin
                    check_value("mtime high word", data, 0);  // counter still small
                end else if (r.resp == resp_okay) begin
                    if (have_low) check_value("mtime low word rising", data > last_low, 1'b1);
                    have_low = 1'b1;
                    last_low = data;
                end
            end
        end

        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
design/fabric_pkg.sv
design/bus_arbiter.sv
design/clint_timer.sv
design/mem_fabric_top.sv
verif/fabric_properties.sv
verif/tb_mem_fabric.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the fabric testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_bin=sim_mem_fabric

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mem_fabric \
    --Mdir "$build_dir" -o "$sim_bin" \
    -f flist.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$("./$build_dir/$sim_bin" 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Regression passed"; then
    exit 0
fi
exit 1
